/* cart_bus_pkg.sv */
package cart_bus_pkg;

	localparam int cpu_addr_w = 15;	// A14..A0, A15 arrives as romsel
	localparam int cpu_data_w = 8;
	localparam int ppu_addr_w = 14;	// PPU A13..A0

	localparam int prg_out_lsb = 13;	// Flash A13, lowest remapped bit
	localparam int prg_out_msb = 26;	// 128M flash
	localparam int chr_out_lsb = 10;	// 1K CHR granularity
	localparam int chr_out_msb = 17;	// 256K CHR RAM

	localparam logic [2:0] cfg_region = 3'b101;	// A14..A12 of $5xxx
	localparam logic [1:0] sram_region = 2'b11;	// A14..A13 of $6000-$7FFF
	localparam logic [1:0] fme7_cmd_port = 2'b00;	// $8000-$9FFF
	localparam logic [1:0] fme7_data_port = 2'b01;	// $A000-$BFFF

	// $5xx0..$5xx7, decoded from A2..A0
	localparam logic [2:0] cfg_base_hi = 3'd0;	// Base A26..A22
	localparam logic [2:0] cfg_base_lo = 3'd1;	// Base A21..A14
	localparam logic [2:0] cfg_mask = 3'd2;	// PRG mask A18..A14
	localparam logic [2:0] cfg_chr0 = 3'd3;	// Direct CHR bank
	localparam logic [2:0] cfg_chr_mask = 3'd4;	// CHR mask A17..A13
	localparam logic [2:0] cfg_prg_sram = 3'd5;	// Direct PRG bank and SRAM page
	localparam logic [2:0] cfg_mapper = 3'd6;	// Flags and mapper code
	localparam logic [2:0] cfg_misc = 3'd7;	// Lockout, mirroring, enables

endpackage

/* mapper_pkg.sv */
package mapper_pkg;

	// Mapper codes as written to $5xx6 bits 4..0
	typedef enum logic [4:0] {
		map_nrom = 5'd0,
		map_uxrom = 5'd1,
		map_cnrom = 5'd2,
		map_axrom = 5'd8,
		map_mmc1 = 5'd16,
		map_fme7 = 5'd25
	} mapper_e;

	// Same order as the FME-7 mirroring register
	typedef enum logic [1:0] {
		mir_vertical,	// CIRAM A10 from PPU A10
		mir_horizontal,	// CIRAM A10 from PPU A11
		mir_single_a,	// Lower nametable only
		mir_single_b	// Upper nametable only
	} mirror_e;

	// Serial loader position, one state per received bit
	typedef enum logic [2:0] {
		ld_bit0,
		ld_bit1,
		ld_bit2,
		ld_bit3,
		ld_bit4
	} mmc1_state_e;

	// FME-7 command register values
	typedef enum logic [3:0] {
		cmd_chr0, cmd_chr1, cmd_chr2, cmd_chr3,
		cmd_chr4, cmd_chr5, cmd_chr6, cmd_chr7,
		cmd_prg0, cmd_prg1, cmd_prg2, cmd_prg3,
		cmd_mirror, cmd_irq_ctrl, cmd_irq_lo, cmd_irq_hi
	} fme7_cmd_e;

endpackage

/* config_regs.sv */
`timescale 1ns/10ps

module config_regs import cart_bus_pkg::*, mapper_pkg::*;
(
	input  logic m2,
	input  logic ppu_addr_in,
	input  logic romsel,
	input  logic cpu_rw,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic [cpu_data_w-1:0] cpu_data,
	output logic [26:14] cpu_base,
	output logic [18:14] cpu_mask,
	output logic [17:13] chr_mask,
	output logic [1:0] sram_page,
	output mapper_e mapper,
	output logic [2:0] flags,
	output logic sram_enabled,
	output logic prg_write_enabled,
	output logic chr_write_enabled,
	output logic cfg_mirror_wr,
	output mirror_e cfg_mirror,
	output logic chr0_load,
	output logic prg_load,
	output logic [7:0] init_data
);
	logic lockout;	// Set once by the loader menu, cleared only by reset
	logic cfg_wr;

	assign cfg_wr = ~cpu_rw & romsel & (cpu_addr[14:12] == cfg_region) & ~lockout;

	// Bank and mirroring pokes go straight to bank_regs in the write cycle
	assign chr0_load = cfg_wr & (cpu_addr[2:0] == cfg_chr0);
	assign prg_load = cfg_wr & (cpu_addr[2:0] == cfg_prg_sram);
	assign cfg_mirror_wr = cfg_wr & (cpu_addr[2:0] == cfg_misc);
	assign cfg_mirror = mirror_e'(cpu_data[4:3]);
	assign init_data = cpu_data;

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			cpu_base <= '0;
			cpu_mask <= '0;
			chr_mask <= '0;
			sram_page <= '0;
			mapper <= map_nrom;
			flags <= '0;
			sram_enabled <= 1'b0;
			prg_write_enabled <= 1'b0;
			chr_write_enabled <= 1'b0;
			lockout <= 1'b0;
		end
		else if (cfg_wr)
		begin
			case (cpu_addr[2:0])
				cfg_base_hi: cpu_base[26:22] <= cpu_data[4:0];
				cfg_base_lo: cpu_base[21:14] <= cpu_data;
				cfg_mask: cpu_mask <= cpu_data[4:0];
				cfg_chr_mask: chr_mask <= cpu_data[4:0];
				cfg_prg_sram: sram_page <= cpu_data[1:0];	// Upper bits are the PRG bank
				cfg_mapper:
				begin
					flags <= cpu_data[7:5];
					mapper <= mapper_e'(cpu_data[4:0]);
				end
				cfg_misc:
				begin
					lockout <= cpu_data[7];
					prg_write_enabled <= cpu_data[2];	// Bits 4..3 are mirroring
					chr_write_enabled <= cpu_data[1];
					sram_enabled <= cpu_data[0];
				end
				default: ;	// $5xx3 only loads the CHR bank
			endcase
		end
	end

endmodule

/* mmc1_loader.sv */
`timescale 1ns/10ps

module mmc1_loader import cart_bus_pkg::*, mapper_pkg::*;
(
	input  logic m2,
	input  logic ppu_addr_in,
	input  logic mmc1_wr,
	input  logic [cpu_data_w-1:0] cpu_data,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	output logic mmc1_commit,
	output logic [4:0] mmc1_value,
	output logic [1:0] mmc1_target
);
	mmc1_state_e state;
	logic [3:0] shift;	// First four bits, newest at the top
	logic bit_wr;	// Data write, not a loader reset

	assign bit_wr = mmc1_wr & ~cpu_data[7];

	// Fifth bit joins from the bus, so the commit lands on its own edge
	assign mmc1_commit = bit_wr & (state == ld_bit4);
	assign mmc1_value = {cpu_data[0], shift};
	assign mmc1_target = cpu_addr[14:13];	// Register picked by the fifth write only

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			state <= ld_bit0;
			shift <= '0;
		end
		else if (mmc1_wr & cpu_data[7])
		begin
			state <= ld_bit0;	// Drop partial value
			shift <= '0;
		end
		else if (bit_wr)
		begin
			shift <= {cpu_data[0], shift[3:1]};
			case (state)
				ld_bit0: state <= ld_bit1;
				ld_bit1: state <= ld_bit2;
				ld_bit2: state <= ld_bit3;
				ld_bit3: state <= ld_bit4;
				default: state <= ld_bit0;	// Commit cycle, start over
			endcase
		end
	end

endmodule

/* fme7_irq_timer.sv */
`timescale 1ns/10ps

module fme7_irq_timer import cart_bus_pkg::*;
(
	input  logic m2,
	input  logic ppu_addr_in,
	input  logic irq_ctrl_wr,
	input  logic lo_wr,
	input  logic hi_wr,
	input  logic [cpu_data_w-1:0] cpu_data,
	output logic irq
);
	logic [15:0] counter;
	logic count_en;	// Control bit 0
	logic irq_en;	// Control bit 7
	logic tick_at_zero;

	assign tick_at_zero = count_en & (counter == 16'd0);

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			counter <= '0;
			count_en <= 1'b0;
			irq_en <= 1'b0;
			irq <= 1'b0;
		end
		else
		begin
			if (lo_wr)
				counter[7:0] <= cpu_data;
			else if (hi_wr)
				counter[15:8] <= cpu_data;
			else if (count_en)
				counter <= counter - 16'd1;	// Wraps to $FFFF after zero

			if (irq_ctrl_wr)
			begin
				count_en <= cpu_data[0];
				irq_en <= cpu_data[7];
				irq <= 1'b0;	// Any control write acks
			end
			else if (tick_at_zero && irq_en)
				irq <= 1'b1;	// Held until acked
		end
	end

endmodule

/* bank_regs.sv */
`timescale 1ns/10ps

module bank_regs import cart_bus_pkg::*, mapper_pkg::*;
#(
	parameter bit use_mmc1 = 1'b1,
	parameter bit use_fme7 = 1'b1
)
(
	input  logic m2,
	input  logic ppu_addr_in,
	input  logic romsel,
	input  logic cpu_rw,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic [cpu_data_w-1:0] cpu_data,
	input  mapper_e mapper,
	input  logic cfg_mirror_wr,
	input  mirror_e cfg_mirror,
	input  logic chr0_load,
	input  logic prg_load,
	input  logic [7:0] init_data,
	output logic [4:0] prg_bank,
	output logic [4:0] chr_bank,
	output logic [4:0] mmc1_ctrl,
	output logic [4:0] mmc1_chr0,
	output logic [4:0] mmc1_chr1,
	output logic [4:0] mmc1_prg,
	output logic [7:0][7:0] fme7_chr,
	output logic [2:0][5:0] fme7_prg,
	output mirror_e mirroring,
	output logic irq
);
	logic map_wr;	// Any write to $8000-$FFFF
	logic mmc1_wr;
	logic mmc1_commit;
	logic [4:0] mmc1_value;
	logic [1:0] mmc1_target;
	logic fme7_wr;
	logic fme7_data_wr;
	fme7_cmd_e fme7_cmd;
	logic [3:0] cmd_idx;
	logic fme7_irq_ctrl_wr;
	logic fme7_lo_wr;
	logic fme7_hi_wr;

	assign map_wr = ~cpu_rw & ~romsel;
	assign mmc1_wr = use_mmc1 && map_wr && (mapper == map_mmc1);
	assign fme7_wr = use_fme7 && map_wr && (mapper == map_fme7);
	assign fme7_data_wr = fme7_wr && (cpu_addr[14:13] == fme7_data_port);
	assign cmd_idx = fme7_cmd;

	// Timer ports
	assign fme7_irq_ctrl_wr = fme7_data_wr && (fme7_cmd == cmd_irq_ctrl);
	assign fme7_lo_wr = fme7_data_wr && (fme7_cmd == cmd_irq_lo);
	assign fme7_hi_wr = fme7_data_wr && (fme7_cmd == cmd_irq_hi);

	mmc1_loader i_mmc1_loader (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .mmc1_wr(mmc1_wr), .cpu_data(cpu_data),
		.cpu_addr(cpu_addr), .mmc1_commit(mmc1_commit), .mmc1_value(mmc1_value),
		.mmc1_target(mmc1_target)
	);

	fme7_irq_timer i_fme7_irq_timer (
		.m2(m2), .ppu_addr_in(ppu_addr_in), .irq_ctrl_wr(fme7_irq_ctrl_wr),
		.lo_wr(fme7_lo_wr), .hi_wr(fme7_hi_wr), .cpu_data(cpu_data), .irq(irq)
	);

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			prg_bank <= '0;
			chr_bank <= '0;
			mmc1_ctrl <= '0;
			mmc1_chr0 <= '0;
			mmc1_chr1 <= '0;
			mmc1_prg <= '0;
			fme7_chr <= '0;
			fme7_prg <= '0;
			fme7_cmd <= cmd_chr0;
			mirroring <= mir_vertical;
		end
		else
		begin
			if (cfg_mirror_wr) mirroring <= cfg_mirror;
			if (chr0_load) chr_bank <= init_data[4:0];
			if (prg_load) prg_bank <= init_data[6:2];	// Bits 1..0 are the SRAM page

			if (map_wr)
			begin
				case (mapper)
					map_uxrom: prg_bank <= cpu_data[4:0];
					map_cnrom: chr_bank <= cpu_data[4:0];
					map_axrom:
					begin
						prg_bank <= cpu_data[4:0];
						mirroring <= cpu_data[4] ? mir_single_b : mir_single_a;
					end
					default: ;	// NROM has no ports
				endcase
			end

			if (mmc1_wr && cpu_data[7]) mmc1_ctrl[3:2] <= 2'b11;	// Fix last bank at $C000
			if (mmc1_commit)
			begin
				case (mmc1_target)
					2'd0:
					begin
						mmc1_ctrl <= mmc1_value;
						mirroring <= mirror_e'(mmc1_value[1:0] ^ 2'b10);	// MMC1 order to ours
					end
					2'd1: mmc1_chr0 <= mmc1_value;
					2'd2: mmc1_chr1 <= mmc1_value;
					default: mmc1_prg <= mmc1_value;
				endcase
			end

			if (fme7_wr && (cpu_addr[14:13] == fme7_cmd_port)) fme7_cmd <= fme7_cmd_e'(cpu_data[3:0]);
			if (fme7_data_wr)
			begin
				case (fme7_cmd)
					cmd_chr0, cmd_chr1, cmd_chr2, cmd_chr3,
					cmd_chr4, cmd_chr5, cmd_chr6, cmd_chr7: fme7_chr[cmd_idx[2:0]] <= cpu_data;
					cmd_prg1, cmd_prg2, cmd_prg3: fme7_prg[cmd_idx[1:0] - 2'd1] <= cpu_data[5:0];
					cmd_mirror: mirroring <= mirror_e'(cpu_data[1:0]);
					default: ;	// $6000 bank unused, SRAM there
				endcase
			end
		end
	end

endmodule

/* addr_mapper.sv */
`timescale 1ns/10ps

module addr_mapper import cart_bus_pkg::*, mapper_pkg::*;
#(
	parameter bit use_mmc1 = 1'b1,
	parameter bit use_fme7 = 1'b1
)
(
	input  logic romsel,
	input  logic cpu_rw,
	input  logic m2,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic ppu_rd,
	input  logic ppu_wr,
	input  logic [ppu_addr_w-1:0] ppu_addr,
	input  logic [26:14] cpu_base,
	input  logic [18:14] cpu_mask,
	input  logic [17:13] chr_mask,
	input  logic [1:0] sram_page,
	input  logic sram_enabled,
	input  logic prg_write_enabled,
	input  logic chr_write_enabled,
	input  mapper_e mapper,
	input  logic [2:0] flags,
	input  logic [4:0] prg_bank,
	input  logic [4:0] chr_bank,
	input  logic [4:0] mmc1_ctrl,
	input  logic [4:0] mmc1_chr0,
	input  logic [4:0] mmc1_chr1,
	input  logic [4:0] mmc1_prg,
	input  logic [7:0][7:0] fme7_chr,
	input  logic [2:0][5:0] fme7_prg,
	input  mirror_e mirroring,
	output logic [prg_out_msb:prg_out_lsb] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [chr_out_msb:chr_out_lsb] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10
);
	logic [18:13] prg_mapped;	// 8K bank before base and mask
	logic [17:10] chr_mapped;	// 1K bank before mask
	logic sel_mmc1;
	logic sel_fme7;

	assign sel_mmc1 = use_mmc1 && (mapper == map_mmc1);
	assign sel_fme7 = use_fme7 && (mapper == map_fme7);

	always_comb
	begin
		if (sel_fme7)
		begin
			case (cpu_addr[14:13])
				2'b00: prg_mapped = fme7_prg[0];
				2'b01: prg_mapped = fme7_prg[1];
				2'b10: prg_mapped = fme7_prg[2];
				default: prg_mapped = '1;	// $E000 fixed last
			endcase
			chr_mapped = fme7_chr[ppu_addr[12:10]];
		end
		else if (sel_mmc1)
		begin
			case (mmc1_ctrl[3:2])
				2'b10: prg_mapped = cpu_addr[14] ? {1'b0, mmc1_prg[3:0], cpu_addr[13]}
					: {5'b00000, cpu_addr[13]};	// First bank at $8000
				2'b11: prg_mapped = cpu_addr[14] ? {5'b01111, cpu_addr[13]}
					: {1'b0, mmc1_prg[3:0], cpu_addr[13]};	// Last bank at $C000
				default: prg_mapped = {1'b0, mmc1_prg[3:1], cpu_addr[14:13]};	// 32K
			endcase
			if (!mmc1_ctrl[4])
				chr_mapped = {1'b0, mmc1_chr0[4:1], ppu_addr[12:10]};	// 8K, low bit ignored
			else if (ppu_addr[12])
				chr_mapped = {1'b0, mmc1_chr1, ppu_addr[11:10]};
			else
				chr_mapped = {1'b0, mmc1_chr0, ppu_addr[11:10]};
		end
		else
		begin
			if (mapper[3])
				prg_mapped = {prg_bank[3:0], cpu_addr[14:13]};	// AxROM-like, 32K
			else if (cpu_addr[14] == flags[0])
				prg_mapped = {prg_bank, cpu_addr[13]};	// Switchable 16K
			else
				prg_mapped = {{5{~flags[0]}}, cpu_addr[13]};	// Last bank, first if flag 0 set
			chr_mapped = {chr_bank, ppu_addr[12:10]};	// Plain 8K
		end
	end

	// Flash below $8000 is never mapped, romsel high means SRAM window
	assign cpu_addr_out = ~romsel ? {cpu_base | {8'd0, prg_mapped[18:14] & ~cpu_mask}, prg_mapped[13]}
		: {12'd0, sram_page};
	assign ppu_addr_out = {chr_mapped[17:13] & ~chr_mask, chr_mapped[12:10]};

	assign flash_we = cpu_rw | romsel | ~prg_write_enabled;
	assign flash_oe = ~cpu_rw | romsel;
	assign sram_ce = ~((cpu_addr[14:13] == sram_region) & m2 & romsel & sram_enabled);
	assign sram_we = cpu_rw;
	assign sram_oe = ~cpu_rw;
	assign ppu_rd_out = ppu_rd | ppu_addr[13];	// Nametables go to CIRAM
	assign ppu_wr_out = ppu_wr | ppu_addr[13] | ~chr_write_enabled;

	always_comb
	begin
		case (mirroring)
			mir_vertical: ppu_ciram_a10 = ppu_addr[10];
			mir_horizontal: ppu_ciram_a10 = ppu_addr[11];
			mir_single_a: ppu_ciram_a10 = 1'b0;
			default: ppu_ciram_a10 = 1'b1;
		endcase
	end

endmodule

/* cool_girl.sv */
`timescale 1ns/10ps

module cool_girl import cart_bus_pkg::*, mapper_pkg::*;
#(
	parameter bit use_mmc1 = 1'b1,	// Mapper 1
	parameter bit use_fme7 = 1'b1	// Mapper 69
)
(
	input  logic m2,
	input  logic ppu_addr_in,	// Async reset, active high
	input  logic romsel,
	input  logic cpu_rw,
	input  logic [cpu_addr_w-1:0] cpu_addr,
	input  logic [cpu_data_w-1:0] cpu_data,
	input  logic ppu_rd,
	input  logic ppu_wr,
	input  logic [ppu_addr_w-1:0] ppu_addr,
	output logic [prg_out_msb:prg_out_lsb] cpu_addr_out,
	output logic flash_we,
	output logic flash_oe,
	output logic sram_ce,
	output logic sram_we,
	output logic sram_oe,
	output logic [chr_out_msb:chr_out_lsb] ppu_addr_out,
	output logic ppu_rd_out,
	output logic ppu_wr_out,
	output logic ppu_ciram_a10,
	output logic irq	// Active-high level
);
	logic [26:14] cpu_base;
	logic [18:14] cpu_mask;
	logic [17:13] chr_mask;
	logic [1:0] sram_page;
	mapper_e mapper;
	logic [2:0] flags;
	logic sram_enabled;
	logic prg_write_enabled;
	logic chr_write_enabled;
	logic cfg_mirror_wr;	// $5xx7 write strobe
	mirror_e cfg_mirror;
	logic chr0_load;	// $5xx3 write strobe
	logic prg_load;	// $5xx5 write strobe
	logic [7:0] init_data;
	logic [4:0] prg_bank;
	logic [4:0] chr_bank;
	logic [4:0] mmc1_ctrl;
	logic [4:0] mmc1_chr0;
	logic [4:0] mmc1_chr1;
	logic [4:0] mmc1_prg;
	logic [7:0][7:0] fme7_chr;
	logic [2:0][5:0] fme7_prg;
	mirror_e mirroring;

	config_regs i_config_regs (.*);

	bank_regs #(
		.use_mmc1(use_mmc1),
		.use_fme7(use_fme7)
	) i_bank_regs (.*);

	addr_mapper #(
		.use_mmc1(use_mmc1),
		.use_fme7(use_fme7)
	) i_addr_mapper (.*);

endmodule

/* cool_girl_sva.sv */
`timescale 1ns/10ps

module cool_girl_sva
(
	input  logic m2,
	input  logic ppu_addr_in,
	input  logic flash_oe,
	input  logic sram_ce,
	input  logic ppu_wr_out,
	input  logic chr_write_enabled,
	input  logic irq
);

	// Both active low, sampled at the end of the m2 high phase
	flash_sram_exclusive: assert property (@(negedge m2) disable iff (ppu_addr_in)
		!(!flash_oe && !sram_ce))
		else $error("flash_oe and sram_ce active together");

	chr_write_blocked: assert property (@(posedge m2) disable iff (ppu_addr_in)
		!chr_write_enabled |-> ppu_wr_out)
		else $error("ppu_wr_out low with CHR writes disabled");

	irq_low_after_reset: assert property (@(posedge m2)
		$fell(ppu_addr_in) |-> !irq)
		else $error("irq high in the first cycle after reset");

endmodule

bind cool_girl cool_girl_sva i_cool_girl_sva (
	.m2(m2),
	.ppu_addr_in(ppu_addr_in),
	.flash_oe(flash_oe),
	.sram_ce(sram_ce),
	.ppu_wr_out(ppu_wr_out),
	.chr_write_enabled(chr_write_enabled),
	.irq(irq)
);

/* tb_cool_girl.sv */
`timescale 1ns/10ps

module tb_cool_girl import cart_bus_pkg::*, mapper_pkg::*;
();

	localparam logic [15:0] op_write = 16'h1;
	localparam logic [15:0] op_prg = 16'h2;
	localparam logic [15:0] op_chr = 16'h3;
	localparam logic [15:0] op_irq = 16'h4;
	localparam logic [15:0] op_mirror = 16'h5;
	localparam logic [15:0] op_select = 16'h6;
	localparam logic [15:0] op_ppu_rd = 16'h7;
	localparam logic [15:0] op_end = 16'hf;
	localparam int stim_words = 512;	// Four words per operation
	localparam int irq_edge_limit = 64;

	logic m2;
	logic ppu_addr_in;
	logic romsel;
	logic cpu_rw;
	logic [cpu_addr_w-1:0] cpu_addr;
	logic [cpu_data_w-1:0] cpu_data;
	logic ppu_rd;
	logic ppu_wr;
	logic [ppu_addr_w-1:0] ppu_addr;
	logic [prg_out_msb:prg_out_lsb] cpu_addr_out;
	logic flash_we;
	logic flash_oe;
	logic sram_ce;
	logic sram_we;
	logic sram_oe;
	logic [chr_out_msb:chr_out_lsb] ppu_addr_out;
	logic ppu_rd_out;
	logic ppu_wr_out;
	logic ppu_ciram_a10;
	logic irq;

	logic [15:0] stim [0:stim_words-1];	// op, addr, data, expected
	int errors;
	int checks;
	logic aborted;

	cool_girl #(
		.use_mmc1(1'b1),
		.use_fme7(1'b1)
	) i_cool_girl (.*);

	initial
	begin
		m2 = 1'b0;
		forever #4 m2 = ~m2;	// 8 ns CPU cycle
	end

	task automatic end_run();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic check_prg(input logic [prg_out_msb:prg_out_lsb] exp);
		checks++;
		if (cpu_addr_out !== exp)
		begin
			errors++;
			$display("Error cpu_addr_out at cpu 0x%h: got 0x%h, expected 0x%h",
				cpu_addr, cpu_addr_out, exp);
		end
	endtask

	task automatic check_chr(input logic [chr_out_msb:chr_out_lsb] exp);
		checks++;
		if (ppu_addr_out !== exp)
		begin
			errors++;
			$display("Error ppu_addr_out at ppu 0x%h: got 0x%h, expected 0x%h",
				ppu_addr, ppu_addr_out, exp);
		end
	endtask

	task automatic check_irq(input logic exp);
		checks++;
		if (irq !== exp)
		begin
			errors++;
			$display("Error irq: got 0x%h, expected 0x%h", irq, exp);
		end
	endtask

	task automatic check_mirror(input mirror_e mode);
		logic exp_a10;
		case (mode)
			mir_vertical: exp_a10 = ppu_addr[10];	// Side by side nametables
			mir_horizontal: exp_a10 = ppu_addr[11];	// Stacked nametables
			mir_single_a: exp_a10 = 1'b0;
			default: exp_a10 = 1'b1;
		endcase
		checks++;
		if (ppu_ciram_a10 !== exp_a10)
		begin
			errors++;
			$display("Error ppu_ciram_a10 (%s, ppu 0x%h): got 0x%h, expected 0x%h",
				mode.name(), ppu_addr, ppu_ciram_a10, exp_a10);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge m2);
		romsel <= ~addr[15];	// Low for $8000-$FFFF
		cpu_addr <= addr[14:0];
		cpu_data <= data;
		cpu_rw <= 1'b0;
		@(posedge m2);
		cpu_rw <= 1'b1;	// Register takes it on this edge
		romsel <= 1'b1;
		cpu_addr <= '0;
		#2;
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		@(posedge m2);
		romsel <= ~addr[15];
		cpu_addr <= addr[14:0];
		cpu_rw <= 1'b1;
		#2;	// Mid high phase of m2
	endtask

	task automatic ppu_read(input logic [15:0] addr);
		@(posedge m2);
		ppu_addr <= addr[ppu_addr_w-1:0];
		ppu_rd <= 1'b0;
		#2;
	endtask

	task automatic wait_irq(input logic level, input int exp_edges);
		int edges;
		edges = 0;
		while (irq !== level && edges < irq_edge_limit)
		begin
			@(posedge m2);
			#2;
			edges++;
		end
		if (irq !== level)
		begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: irq never went to %0b within %0d m2 edges", level, edges);
		end
		else
		begin
			checks++;
			if (edges != exp_edges)
			begin
				errors++;
				$display("Error irq edge count: got 0x%h, expected 0x%h", edges, exp_edges);
			end
			@(posedge m2);
			#2;
			check_irq(level);	// Held until the next control write
		end
	endtask

	task automatic run_op(input logic [15:0] op, input logic [15:0] addr,
		input logic [15:0] data, input logic [15:0] exp_val);
		case (op)
			op_write: cpu_write(addr, data[7:0]);
			op_prg:
			begin
				cpu_read(addr);
				check_prg(exp_val[13:0]);
			end
			op_chr:
			begin
				ppu_read(addr);
				check_chr(exp_val[7:0]);
			end
			op_irq: wait_irq(exp_val[0], int'(addr));	// Addr column holds the edge count
			op_mirror:
			begin
				ppu_read(addr);
				check_mirror(mirror_e'(data[1:0]));
			end
			op_select:
			begin
				cpu_read(addr);
				check_level("flash_oe", flash_oe, exp_val[1]);
				check_level("sram_ce", sram_ce, exp_val[0]);
				check_level("flash_we", flash_we, 1'b1);	// Reads never write
				check_level("sram_we", sram_we, 1'b1);
				check_level("sram_oe", sram_oe, 1'b0);
			end
			op_ppu_rd:
			begin
				ppu_read(addr);
				check_level("ppu_rd_out", ppu_rd_out, exp_val[0]);
				check_level("ppu_wr_out", ppu_wr_out, 1'b1);	// Read cycle, no CHR write
			end
			default:
			begin
				errors++;
				aborted = 1'b1;
				$display("Unknown operation 0x%h in the stimulus file", op);
			end
		endcase
	endtask

	initial
	begin
		int pc;
		errors = 0;
		checks = 0;
		aborted = 1'b0;
		ppu_addr_in = 1'b1;	// Held from time zero
		romsel = 1'b1;
		cpu_rw = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		ppu_rd = 1'b1;
		ppu_wr = 1'b1;
		ppu_addr = '0;
		$readmemh("cool_girl_stim.txt", stim);
		repeat (10) @(posedge m2);
		ppu_addr_in <= 1'b0;
		pc = 0;
		while (!aborted && pc < stim_words && stim[pc] !== op_end)
		begin
			run_op(stim[pc], stim[pc + 1], stim[pc + 2], stim[pc + 3]);
			pc = pc + 4;
		end
		if (pc >= stim_words)
		begin
			errors++;
			$display("Stimulus ran out without an end marker");
		end
		end_run();
	end

	initial
	begin
		#200000;	// Watchdog, far beyond the stimulus length
		errors++;
		$display("Timeout: the run did not reach its end");
		end_run();
	end

endmodule

/* cool_girl_stim.txt */
// Columns in hex: op addr data expected. Ops 1 write, 2 cpu_addr_out, 3 ppu_addr_out,
// 4 wait irq (addr = m2 edges), 5 ciram mode in data, 6 {flash_oe,sram_ce}, 7 ppu_rd_out, f end
// UxROM, base $400000, PRG mask $18
1 5000 01 0000
1 5001 00 0000
1 5002 18 0000
1 5006 01 0000
1 8000 05 0000
2 8000 00 020a
2 c000 00 020e
2 e000 00 020f
// CNROM under CHR mask $10
1 5004 10 0000
1 5006 02 0000
1 8000 13 0000
3 0400 00 0019
// AxROM, bit 4 selects the upper nametable
1 5006 08 0000
1 8000 12 0000
2 8000 00 0208
2 c000 00 020a
5 2000 03 0000
1 8000 02 0000
5 2400 02 0000
// MMC1, two bits dropped by a bit 7 write, then prg = 3
1 5006 10 0000
1 e000 01 0000
1 e000 01 0000
1 8000 80 0000
1 e000 01 0000
1 e000 01 0000
1 e000 00 0000
1 e000 00 0000
1 e000 00 0000
2 8000 00 0206
2 c000 00 020e
// MMC1 ctrl = $0a, 16K at $C000, vertical
1 8000 00 0000
1 8000 01 0000
1 8000 00 0000
1 8000 01 0000
1 8000 00 0000
2 8000 00 0200
2 c000 00 0206
5 2400 00 0000
5 2800 00 0000
// MMC1 chr0 = 6 in 8K mode
1 a000 00 0000
1 a000 01 0000
1 a000 01 0000
1 a000 00 0000
1 a000 00 0000
3 1c00 00 001f
// FME-7 CHR and PRG banks
1 5006 19 0000
1 8000 00 0000
1 a000 05 0000
1 8000 07 0000
1 a000 9a 0000
3 0000 00 0005
3 1c00 00 001a
1 8000 09 0000
1 a000 04 0000
1 8000 0a 0000
1 a000 06 0000
1 8000 0b 0000
1 a000 0b 0000
2 8000 00 0204
2 a000 00 0206
2 c000 00 020b
2 e000 00 020f
1 8000 0c 0000
1 a000 01 0000
5 2400 01 0000
5 2800 01 0000
// FME-7 IRQ with a count of 5, then the ack
1 8000 0e 0000
1 a000 05 0000
1 8000 0f 0000
1 a000 00 0000
1 8000 0d 0000
1 a000 81 0000
4 0006 00 0001
1 a000 00 0000
4 0000 00 0000
// SRAM page 2 and chip selects
1 5005 02 0000
1 5007 01 0000
2 6000 00 0002
6 6000 00 0002
6 8000 00 0001
7 2000 00 0001
7 0000 00 0000
// Lockout blocks later base and mapper writes
1 5007 81 0000
1 5000 03 0000
1 5006 01 0000
2 8000 00 0204
f 0000 00 0000

/* cool_girl.f */
cart_bus_pkg.sv
mapper_pkg.sv
config_regs.sv
mmc1_loader.sv
fme7_irq_timer.sv
bank_regs.sv
addr_mapper.sv
cool_girl.sv
cool_girl_sva.sv
tb_cool_girl.sv

/* Bender.yml */
package:
  name: cool_girl

sources:
  - cart_bus_pkg.sv
  - mapper_pkg.sv
  - config_regs.sv
  - mmc1_loader.sv
  - fme7_irq_timer.sv
  - bank_regs.sv
  - addr_mapper.sv
  - cool_girl.sv
  - target: test
    files:
      - cool_girl_sva.sv
      - tb_cool_girl.sv
